/* design/echo_settings.svh */
//////////////////////////////////////////////////
// Build settings of the UDP echo engine
// Include in any file that needs the echo port,
// the local address, the reply TTL or FIFO depth
//////////////////////////////////////////////////

`ifndef ECHO_SETTINGS_SVH
`define ECHO_SETTINGS_SVH

// UDP port answered by the engine
`define ECHO_UDP_PORT 16'd1234

// Local address, 192.168.1.128
`define ECHO_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// TTL placed in every reply
`define ECHO_TTL 8'd64

// Payload FIFO address width, 256 entries
`define ECHO_FIFO_ADDR_WIDTH 8

`endif

/* design/udp_field_pkg.sv */
//////////////////////////////////////////////////
// UDP/IP header field types used on the header
// channels of the echo engine
//////////////////////////////////////////////////

package udp_field_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [15:0] udp_csum_t;

    // IP header fields that the reply sets
    typedef logic [7:0] ip_ttl_t;
    typedef logic [5:0] ip_dscp_t;
    typedef logic [1:0] ip_ecn_t;

endpackage

/* design/byte_stream_pkg.sv */
//////////////////////////////////////////////////
// Payload byte stream types and FIFO pointer types
// Pointer types are taken per FIFO instance
//////////////////////////////////////////////////

package byte_stream_pkg;

    // One payload byte
    typedef logic [7:0] payload_byte_t;

    // Address and pointer types for a FIFO of 2**addr_width entries,
    // the pointer carries one extra wrap bit
    virtual class fifo_ptr #(parameter int addr_width);
        typedef logic [addr_width-1:0] addr_t;
        typedef logic [addr_width:0] ptr_t;
    endclass

endpackage

/* design/echo_port_filter.sv */
//////////////////////////////////////////////////
// Echo or discard decision per datagram
// Passes echo payload to the FIFO and sinks the
// payload of any other port
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "echo_settings.svh"

module echo_port_filter
    import udp_field_pkg::*, byte_stream_pkg::*;
(
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,

    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  udp_port_t     in_dst_port,

    input  logic          in_valid,
    output logic          in_ready,
    input  payload_byte_t in_data,
    input  logic          in_last,
    input  logic          in_user,

    output logic          reply_hdr_valid,
    input  logic          reply_hdr_ready,

    output logic          fifo_wr_valid,
    input  logic          fifo_wr_ready,
    output payload_byte_t fifo_wr_data,
    output logic          fifo_wr_last,
    output logic          fifo_wr_user
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DISCARD
    } frame_state_t;

    frame_state_t state;
    logic         hdr_armed;
    logic         port_match;
    logic         hdr_xfer;
    logic         byte_xfer;

    assign port_match = (in_dst_port == `ECHO_UDP_PORT);

    // Matching headers also need room in the header builder
    assign reply_hdr_valid = in_hdr_valid && hdr_armed && (state == ST_IDLE) && port_match;
    assign in_hdr_ready    = hdr_armed && (state == ST_IDLE) && (!port_match || reply_hdr_ready);
    assign hdr_xfer        = in_hdr_valid && in_hdr_ready;

    // Discarded bytes are sunk every cycle
    assign in_ready  = ((state == ST_FORWARD) && fifo_wr_ready) || (state == ST_DISCARD);
    assign byte_xfer = in_valid && in_ready;

    assign fifo_wr_valid = in_valid && (state == ST_FORWARD);
    assign fifo_wr_data  = in_data;
    assign fifo_wr_last  = in_last;
    assign fifo_wr_user  = in_user;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state     <= ST_IDLE;
            hdr_armed <= 1'b0;
        end else begin
            // Header channel opens one cycle after reset
            hdr_armed <= 1'b1;
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_FORWARD : ST_DISCARD;
                    end
                end
                ST_FORWARD, ST_DISCARD: begin
                    if (byte_xfer && in_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // A payload byte held back, also while idle, stays put until taken
    assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (in_valid && !in_ready) |=> in_valid && $stable({in_data, in_last, in_user}))
        else $error("payload byte changed while stalled");

endmodule

/* design/echo_header_builder.sv */
//////////////////////////////////////////////////
// One-entry register that builds the reply header
// from the header of an echoed datagram
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "echo_settings.svh"

module echo_header_builder
    import udp_field_pkg::*;
(
    input  logic      clk_125mhz,
    input  logic      rst_125mhz,

    input  logic      reply_hdr_valid,
    output logic      reply_hdr_ready,
    input  ip_addr_t  in_src_ip,
    input  udp_port_t in_src_port,
    input  udp_port_t in_dst_port,
    input  udp_len_t  in_length,

    output logic      out_hdr_valid,
    input  logic      out_hdr_ready,
    output ip_addr_t  out_src_ip,
    output ip_addr_t  out_dst_ip,
    output udp_port_t out_src_port,
    output udp_port_t out_dst_port,
    output udp_len_t  out_length,
    output ip_ttl_t   out_ttl,
    output ip_dscp_t  out_dscp,
    output ip_ecn_t   out_ecn,
    output udp_csum_t out_checksum
);

    logic load;

    // Free when empty or when the held header leaves this cycle
    assign reply_hdr_ready = !out_hdr_valid || out_hdr_ready;
    assign load            = reply_hdr_valid && reply_hdr_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            out_hdr_valid <= 1'b0;
        end else if (load) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (load) begin
            // Reply goes back to the sender with the ports swapped
            out_src_ip   <= `ECHO_LOCAL_IP;
            out_dst_ip   <= in_src_ip;
            out_src_port <= in_dst_port;
            out_dst_port <= in_src_port;
            out_length   <= in_length;
            out_ttl      <= `ECHO_TTL;
            out_dscp     <= '0;
            out_ecn      <= '0;
            // No UDP checksum
            out_checksum <= '0;
        end
    end

    // A stalled header holds its fields until taken
    assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (out_hdr_valid && !out_hdr_ready) |=> out_hdr_valid && $stable({out_src_ip,
            out_dst_ip, out_src_port, out_dst_port, out_length, out_ttl, out_dscp,
            out_ecn, out_checksum}))
        else $error("reply header changed while stalled");

endmodule

/* design/payload_fifo.sv */
//////////////////////////////////////////////////
// Synchronous byte FIFO with last and user flags
// Depth is 2**addr_width, data readable one cycle
// after it is written
//////////////////////////////////////////////////

`timescale 1ns/1ps

module payload_fifo
    import byte_stream_pkg::*;
#(
    // Overridden by the top level
    parameter int addr_width = 4
) (
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,

    input  logic          wr_valid,
    output logic          wr_ready,
    input  payload_byte_t wr_data,
    input  logic          wr_last,
    input  logic          wr_user,

    output logic          rd_valid,
    input  logic          rd_ready,
    output payload_byte_t rd_data,
    output logic          rd_last,
    output logic          rd_user
);

    typedef fifo_ptr#(addr_width)::addr_t addr_t;
    typedef fifo_ptr#(addr_width)::ptr_t ptr_t;

    localparam int entry_width = $bits(payload_byte_t) + 2;
    localparam int depth = 2 ** addr_width;

    // Entry is {user, last, data}
    logic [entry_width-1:0] mem [depth];

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    addr_t wr_addr;
    addr_t rd_addr;
    logic  full;
    logic  empty;
    logic  wr_en;
    logic  rd_en;

    assign wr_addr = wr_ptr[addr_width-1:0];
    assign rd_addr = rd_ptr[addr_width-1:0];

    // Same address with differing wrap bits means full
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) && (wr_addr == rd_addr);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign wr_en    = wr_valid && wr_ready;
    assign rd_en    = rd_valid && rd_ready;

    assign {rd_user, rd_last, rd_data} = mem[rd_addr];

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_addr] <= {wr_user, wr_last, wr_data};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy must stay below depth when a write lands
    assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        wr_en |-> (ptr_t'(wr_ptr - rd_ptr) < ptr_t'(depth)))
        else $error("write into full payload FIFO");

endmodule

/* design/first_byte_led.sv */
//////////////////////////////////////////////////
// Shows the first outgoing payload byte of each
// echoed datagram on the LEDs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module first_byte_led
    import byte_stream_pkg::*;
(
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,
    input  logic          out_valid,
    input  logic          out_ready,
    input  logic          out_last,
    input  payload_byte_t out_data,
    output logic [7:0]    led
);

    // Set when the next transferred byte opens a datagram
    logic at_start;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            at_start <= 1'b1;
            led      <= '0;
        end else if (out_valid && out_ready) begin
            if (at_start) begin
                led <= out_data;
            end
            at_start <= out_last;
        end
    end

endmodule

/* design/udp_echo_core.sv */
//////////////////////////////////////////////////
// UDP echo engine top level
// Takes parsed UDP datagrams and returns replies
// for the echo port, other datagrams are dropped
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "echo_settings.svh"

module udp_echo_core
    import udp_field_pkg::*, byte_stream_pkg::*;
(
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,

    // Received UDP header
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  ip_addr_t      in_src_ip,
    input  udp_port_t     in_src_port,
    input  udp_port_t     in_dst_port,
    input  udp_len_t      in_length,

    // Received payload
    input  payload_byte_t in_data,
    input  logic          in_valid,
    output logic          in_ready,
    input  logic          in_last,
    input  logic          in_user,

    // Reply header
    output logic          out_hdr_valid,
    input  logic          out_hdr_ready,
    output ip_addr_t      out_src_ip,
    output ip_addr_t      out_dst_ip,
    output udp_port_t     out_src_port,
    output udp_port_t     out_dst_port,
    output udp_len_t      out_length,
    output ip_ttl_t       out_ttl,
    output ip_dscp_t      out_dscp,
    output ip_ecn_t       out_ecn,
    output udp_csum_t     out_checksum,

    // Reply payload
    output payload_byte_t out_data,
    output logic          out_valid,
    input  logic          out_ready,
    output logic          out_last,
    output logic          out_user,

    output logic [7:0]    led
);

    // Filter to header builder
    logic reply_hdr_valid;
    logic reply_hdr_ready;

    // Filter to payload FIFO
    logic          fifo_wr_valid;
    logic          fifo_wr_ready;
    payload_byte_t fifo_wr_data;
    logic          fifo_wr_last;
    logic          fifo_wr_user;

    echo_port_filter echo_port_filter_inst (
        .clk_125mhz      (clk_125mhz),
        .rst_125mhz      (rst_125mhz),
        .in_hdr_valid    (in_hdr_valid),
        .in_hdr_ready    (in_hdr_ready),
        .in_dst_port     (in_dst_port),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_data         (in_data),
        .in_last         (in_last),
        .in_user         (in_user),
        .reply_hdr_valid (reply_hdr_valid),
        .reply_hdr_ready (reply_hdr_ready),
        .fifo_wr_valid   (fifo_wr_valid),
        .fifo_wr_ready   (fifo_wr_ready),
        .fifo_wr_data    (fifo_wr_data),
        .fifo_wr_last    (fifo_wr_last),
        .fifo_wr_user    (fifo_wr_user)
    );

    echo_header_builder echo_header_builder_inst (
        .clk_125mhz      (clk_125mhz),
        .rst_125mhz      (rst_125mhz),
        .reply_hdr_valid (reply_hdr_valid),
        .reply_hdr_ready (reply_hdr_ready),
        .in_src_ip       (in_src_ip),
        .in_src_port     (in_src_port),
        .in_dst_port     (in_dst_port),
        .in_length       (in_length),
        .out_hdr_valid   (out_hdr_valid),
        .out_hdr_ready   (out_hdr_ready),
        .out_src_ip      (out_src_ip),
        .out_dst_ip      (out_dst_ip),
        .out_src_port    (out_src_port),
        .out_dst_port    (out_dst_port),
        .out_length      (out_length),
        .out_ttl         (out_ttl),
        .out_dscp        (out_dscp),
        .out_ecn         (out_ecn),
        .out_checksum    (out_checksum)
    );

    payload_fifo #(
        .addr_width (`ECHO_FIFO_ADDR_WIDTH)
    ) payload_fifo_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_valid   (fifo_wr_valid),
        .wr_ready   (fifo_wr_ready),
        .wr_data    (fifo_wr_data),
        .wr_last    (fifo_wr_last),
        .wr_user    (fifo_wr_user),
        .rd_valid   (out_valid),
        .rd_ready   (out_ready),
        .rd_data    (out_data),
        .rd_last    (out_last),
        .rd_user    (out_user)
    );

    first_byte_led first_byte_led_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .out_data   (out_data),
        .led        (led)
    );

endmodule

/* test/clock_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and reset source
// 125 MHz clock, reset held high for the first
// reset_cycles rising edges
//////////////////////////////////////////////////

`timescale 1ns/1ps

module clock_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 8
) (
    output logic clk_125mhz,
    output logic rst_125mhz
);

    initial begin
        clk_125mhz = 1'b0;
        forever #(period_ns / 2.0) clk_125mhz = ~clk_125mhz;
    end

    // Released on an edge, like any other synchronous input
    initial begin
        rst_125mhz = 1'b1;
        repeat (reset_cycles) @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;
    end

endmodule

/* test/udp_echo_tb.sv */
//////////////////////////////////////////////////
// Testbench of the UDP echo engine
// Sends echo and discard datagrams, predicts the
// replies and checks headers, payload and LEDs
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "echo_settings.svh"

module udp_echo_tb
    import udp_field_pkg::*, byte_stream_pkg::*;
();

    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
        ip_ttl_t   ttl;
        ip_dscp_t  dscp;
        ip_ecn_t   ecn;
        udp_csum_t checksum;
    } reply_hdr_t;

    logic clk_125mhz;
    logic rst_125mhz;

    logic          in_hdr_valid;
    logic          in_hdr_ready;
    ip_addr_t      in_src_ip;
    udp_port_t     in_src_port;
    udp_port_t     in_dst_port;
    udp_len_t      in_length;
    payload_byte_t in_data;
    logic          in_valid;
    logic          in_ready;
    logic          in_last;
    logic          in_user;
    logic          out_hdr_valid;
    logic          out_hdr_ready;
    ip_addr_t      out_src_ip;
    ip_addr_t      out_dst_ip;
    udp_port_t     out_src_port;
    udp_port_t     out_dst_port;
    udp_len_t      out_length;
    ip_ttl_t       out_ttl;
    ip_dscp_t      out_dscp;
    ip_ecn_t       out_ecn;
    udp_csum_t     out_checksum;
    payload_byte_t out_data;
    logic          out_valid;
    logic          out_ready;
    logic          out_last;
    logic          out_user;
    logic [7:0]    led;

    // Expected replies, payload entries are {user, last, data}
    reply_hdr_t  exp_hdr_q[$];
    logic [9:0]  exp_byte_q[$];
    reply_hdr_t  exp_hdr;
    logic [9:0]  exp_byte;
    logic        at_first = 1'b1;
    logic        led_pending = 1'b0;
    logic [7:0]  led_expected;
    logic        random_ready = 1'b0;
    int unsigned bytes_sent = 0;
    string       test_name = "reset";

    clock_gen clock_gen_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz)
    );

    udp_echo_core udp_echo_core_inst (.*);

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Error: test %s, %s expected 0x%0h actual 0x%0h",
                               test_name, what, expected, actual));
        end
    endtask

    // Echo rule: only the echo port is answered, back to the sender
    function automatic logic predict_reply(input ip_addr_t src_ip, input udp_port_t src_port,
                                           input udp_port_t dst_port, input udp_len_t length,
                                           output reply_hdr_t reply);
        reply.src_ip   = `ECHO_LOCAL_IP;
        reply.dst_ip   = src_ip;
        reply.src_port = dst_port;
        reply.dst_port = src_port;
        reply.length   = length;
        reply.ttl      = `ECHO_TTL;
        reply.dscp     = '0;
        reply.ecn      = '0;
        reply.checksum = '0;
        return (dst_port == `ECHO_UDP_PORT);
    endfunction

    // Header then payload with random contents, called on a rising edge
    task automatic send_datagram(input udp_port_t dst_port, input int len);
        ip_addr_t      src_ip;
        udp_port_t     src_port;
        reply_hdr_t    reply;
        payload_byte_t data;
        logic          user;
        logic          echo;
        src_ip   = $urandom;
        src_port = $urandom;
        echo     = predict_reply(src_ip, src_port, dst_port, udp_len_t'(len + 8), reply);
        if (echo) begin
            exp_hdr_q.push_back(reply);
        end
        in_hdr_valid <= 1'b1;
        in_src_ip    <= src_ip;
        in_src_port  <= src_port;
        in_dst_port  <= dst_port;
        in_length    <= udp_len_t'(len + 8);
        @(posedge clk_125mhz);
        while (!in_hdr_ready) @(posedge clk_125mhz);
        in_hdr_valid <= 1'b0;
        for (int i = 0; i < len; i++) begin
            data = $urandom;
            user = $urandom_range(0, 1);
            if (echo) begin
                exp_byte_q.push_back({user, (i == len - 1), data});
            end
            in_valid <= 1'b1;
            in_data  <= data;
            in_last  <= (i == len - 1);
            in_user  <= user;
            @(posedge clk_125mhz);
            while (!in_ready) @(posedge clk_125mhz);
            bytes_sent++;
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0 || led_pending) begin
            @(posedge clk_125mhz);
        end
        // Room for any stray output to show up
        repeat (20) @(posedge clk_125mhz);
    endtask

    // Output back-pressure
    always @(posedge clk_125mhz) begin
        if (random_ready) begin
            out_ready     <= $urandom_range(0, 1);
            out_hdr_ready <= $urandom_range(0, 1);
        end else begin
            out_ready     <= 1'b1;
            out_hdr_ready <= 1'b1;
        end
    end

    // Compare every output transfer with the expected queues
    always @(posedge clk_125mhz) begin
        if (!rst_125mhz) begin
            // led was loaded by the first byte and is settled now
            if (led_pending) begin
                check_value("led", led_expected, led);
                led_pending = 1'b0;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    fail_run("Reply header appeared with no echoed datagram waiting for it");
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    check_value("hdr src_ip", exp_hdr.src_ip, out_src_ip);
                    check_value("hdr dst_ip", exp_hdr.dst_ip, out_dst_ip);
                    check_value("hdr src_port", exp_hdr.src_port, out_src_port);
                    check_value("hdr dst_port", exp_hdr.dst_port, out_dst_port);
                    check_value("hdr length", exp_hdr.length, out_length);
                    check_value("hdr ttl", exp_hdr.ttl, out_ttl);
                    check_value("hdr dscp", exp_hdr.dscp, out_dscp);
                    check_value("hdr ecn", exp_hdr.ecn, out_ecn);
                    check_value("hdr checksum", exp_hdr.checksum, out_checksum);
                end
            end
            if (out_valid && out_ready) begin
                if (exp_byte_q.size() == 0) begin
                    fail_run("Payload byte appeared with no echoed payload waiting for it");
                end else begin
                    exp_byte = exp_byte_q.pop_front();
                    check_value("payload data", exp_byte[7:0], out_data);
                    check_value("payload last", exp_byte[8], out_last);
                    check_value("payload user", exp_byte[9], out_user);
                    if (at_first) begin
                        led_expected = exp_byte[7:0];
                    end
                    at_first    = exp_byte[8];
                    led_pending = exp_byte[8];
                end
            end
        end
    end

    // Budget grows with every byte sent
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge clk_125mhz);
            cycles++;
            if (cycles > 200 * bytes_sent + 1000) begin
                fail_run($sformatf("Timeout: reply output stalled after %0d cycles", cycles));
            end
        end
    end

    initial begin : stimulus
        udp_port_t dst_port;
        void'($urandom(32'hc6de_144a));
        in_hdr_valid  = 1'b0;
        in_src_ip     = '0;
        in_src_port   = '0;
        in_dst_port   = '0;
        in_length     = '0;
        in_data       = '0;
        in_valid      = 1'b0;
        in_last       = 1'b0;
        in_user       = 1'b0;
        out_hdr_ready = 1'b1;
        out_ready     = 1'b1;

        @(posedge clk_125mhz);
        while (rst_125mhz) @(posedge clk_125mhz);
        check_value("out_hdr_valid", 1'b0, out_hdr_valid);
        check_value("out_valid", 1'b0, out_valid);
        check_value("led", 8'h00, led);

        test_name = "echo";
        send_datagram(`ECHO_UDP_PORT, 12);
        wait_drain();

        test_name = "discard";
        send_datagram(16'd5000, 9);
        send_datagram(`ECHO_UDP_PORT, 5);
        wait_drain();

        test_name = "random mix";
        random_ready = 1'b1;
        for (int n = 0; n < 20; n++) begin
            dst_port = $urandom_range(0, 1) ? udp_port_t'(`ECHO_UDP_PORT) : udp_port_t'($urandom);
            send_datagram(dst_port, $urandom_range(1, 24));
            repeat ($urandom_range(0, 3)) @(posedge clk_125mhz);
        end
        wait_drain();
        random_ready = 1'b0;

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/udp_field_pkg.sv
design/byte_stream_pkg.sv
design/echo_port_filter.sv
design/echo_header_builder.sv
design/payload_fifo.sv
design/first_byte_led.sv
design/udp_echo_core.sv
test/clock_gen.sv
test/udp_echo_tb.sv
